// File: include/aib_sync_config.svh
/*
  Sizing and register map for the AIB config/status crossing.
  AIB_SYNC_STAGES must be 2 or more. Addresses must fit in AIB_CFG_ADDR_W.
*/
`ifndef AIB_SYNC_CONFIG_SVH
`define AIB_SYNC_CONFIG_SVH

// ----------------------------------------------------------
// Synchronizer depth
// ----------------------------------------------------------
`define AIB_SYNC_STAGES 2          // Flops per bit synchronizer

// ----------------------------------------------------------
// Register port geometry
// ----------------------------------------------------------
`define AIB_CFG_ADDR_W 2           // Register address bits
`define AIB_CFG_DATA_W 16          // Register data bits

// Register map
`define AIB_ADDR_TX_CFG    2'd0    // Transmit config, read/write
`define AIB_ADDR_RX_STATUS 2'd1    // Crossed status, read only
`define AIB_ADDR_ID        2'd2    // Block ID, read only

`define AIB_ID_VALUE 16'hA1B5      // ID constant

`endif

// File: hdl/aib_sync_pkg.sv
/*
  Shared types for the config/status crossing.
  Field order is high to low and matches the register layout.
*/
`include "aib_sync_config.svh"

package aib_sync_pkg;

  // ----------------------------------------------------------
  // Plain vectors
  // ----------------------------------------------------------
  typedef logic [`AIB_CFG_ADDR_W-1:0] cfg_addr_t;   // Register address
  typedef logic [`AIB_CFG_DATA_W-1:0] cfg_data_t;   // Register data
  typedef logic [7:0]                 err_count_t;  // Saturating error count

  // ----------------------------------------------------------
  // Transmit config, low 8 bits of the config register
  // ----------------------------------------------------------
  typedef struct packed {
    logic       enable;     // Link enable, gates error counting
    logic       err_clr;    // Level clear of count and flag
    logic [1:0] tx_mode;    // Transmit mode select
    logic [3:0] lane_mask;  // Per-lane enable
  } tx_cfg_t;

  // Receive status, low 10 bits of the status register
  typedef struct packed {
    logic       link_up;    // Registered link level
    logic       err_seen;   // Sticky error flag
    err_count_t err_count;  // Counted error pulses
  } rx_status_t;

endpackage

// File: hdl/aib_bit_sync.sv
/*
  Single-bit synchronizer, AIB_SYNC_STAGES flops deep (2 or more).
  For levels or toggles only. A one-cycle pulse may be lost.
*/
`timescale 1ns/1ns
`include "aib_sync_config.svh"

module aib_bit_sync (
  input  logic clk,       // Destination clock
  input  logic rst_n,     // Async reset, already synchronized
  input  logic data_in,   // Bit from the other domain
  output logic data_out   // Bit in the clk domain
);

  localparam int STAGES = `AIB_SYNC_STAGES;

  logic [STAGES-1:0] sync_q;  // Shift chain, bit 0 is the capture flop

  // First flop may go metastable, later ones settle it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q <= {sync_q[STAGES-2:0], data_in};
    end
  end

  assign data_out = sync_q[STAGES-1];  // Last stage only

endmodule

// File: hdl/aib_bus_sync.sv
/*
  Toggle request/acknowledge bus crossing. Only values held in the source
  register cross, so a steady input converges but fast changes are skipped.
*/
`timescale 1ns/1ns

module aib_bus_sync #(
  parameter int                DWIDTH    = 1,
  parameter logic [DWIDTH-1:0] RESET_VAL = '0
) (
  input  logic              src_clk,     // Source clock
  input  logic              src_rst_n,   // Source async reset
  input  logic              dest_clk,    // Destination clock
  input  logic              dest_rst_n,  // Destination async reset
  input  logic [DWIDTH-1:0] src_data,    // Bus in the source domain
  output logic [DWIDTH-1:0] dest_data    // Bus in the destination domain
);

  logic              src_req_q;      // Request toggle
  logic [DWIDTH-1:0] src_data_q;     // Held copy of src_data
  logic              ack_sync;       // Acknowledge seen in src domain
  logic              src_idle;       // No transfer in flight
  logic              req_sync;       // Request seen in dest domain
  logic              dest_ack_q;     // Acknowledge toggle
  logic              dest_sample;    // New request has arrived

  // ----------------------------------------------------------
  // Source domain
  // ----------------------------------------------------------
  assign src_idle = (src_req_q == ack_sync);  // Last request answered

  // Capture and request together, data stays put until acked
  always_ff @(posedge src_clk or negedge src_rst_n)
  begin
    if (!src_rst_n)
    begin
      src_req_q  <= 1'b0;
      src_data_q <= RESET_VAL;
    end
    else if (src_idle)
    begin
      src_req_q  <= ~src_req_q;
      src_data_q <= src_data;
    end
  end

  aib_bit_sync u_ack_sync (
    .clk      (src_clk),
    .rst_n    (src_rst_n),
    .data_in  (dest_ack_q),
    .data_out (ack_sync)
  );

  // ----------------------------------------------------------
  // Destination domain
  // ----------------------------------------------------------
  aib_bit_sync u_req_sync (
    .clk      (dest_clk),
    .rst_n    (dest_rst_n),
    .data_in  (src_req_q),
    .data_out (req_sync)
  );

  assign dest_sample = req_sync ^ dest_ack_q;  // One cycle per toggle

  always_ff @(posedge dest_clk or negedge dest_rst_n)
  begin
    if (!dest_rst_n)
    begin
      dest_ack_q <= 1'b0;
      dest_data  <= RESET_VAL;
    end
    else
    begin
      dest_ack_q <= req_sync;                  // Echo request back
      if (dest_sample)
        dest_data <= src_data_q;               // Source is stable here
    end
  end

endmodule

// File: hdl/aib_cfg_regs.sv
/*
  Register file on the src_clk side with plain write and read strobes.
  Reads are registered with one cycle latency. Only the config register is writable.
*/
`timescale 1ns/1ns
`include "aib_sync_config.svh"

module aib_cfg_regs (
  input  logic                       src_clk,     // Register clock
  input  logic                       src_rst_n,   // Async reset
  input  logic                       wr_en,       // Write strobe
  input  logic                       rd_en,       // Read strobe
  input  aib_sync_pkg::cfg_addr_t    addr,        // Shared by read and write
  input  aib_sync_pkg::cfg_data_t    wdata,       // Write data
  input  aib_sync_pkg::rx_status_t   src_status,  // Status already crossed
  output aib_sync_pkg::cfg_data_t    rdata,       // Registered read data
  output logic                       rd_valid,    // Read data strobe
  output aib_sync_pkg::tx_cfg_t      src_cfg      // Config to the crossing
);

  localparam int DATA_W = `AIB_CFG_DATA_W;
  localparam int CFG_W  = $bits(aib_sync_pkg::tx_cfg_t);
  localparam int STAT_W = $bits(aib_sync_pkg::rx_status_t);

  logic                    wr_cfg;     // Write hits the config register
  aib_sync_pkg::tx_cfg_t   cfg_q;      // Config register
  aib_sync_pkg::cfg_data_t cfg_rd;     // Config, zero extended
  aib_sync_pkg::cfg_data_t status_rd;  // Status, zero extended
  aib_sync_pkg::cfg_data_t rd_mux;     // Selected read value

  // ----------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------

  // Status, ID and spare addresses drop writes
  assign wr_cfg = wr_en && (addr == `AIB_ADDR_TX_CFG);

  // Config register
  always_ff @(posedge src_clk or negedge src_rst_n)
  begin
    if (!src_rst_n)
    begin
      cfg_q <= '0;
    end
    else if (wr_cfg)
    begin
      cfg_q <= wdata[CFG_W-1:0];  // Upper data bits ignored
    end
  end

  assign src_cfg = cfg_q;

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------

  // Zero fill above the used fields
  assign cfg_rd    = {{(DATA_W-CFG_W){1'b0}}, cfg_q};
  assign status_rd = {{(DATA_W-STAT_W){1'b0}}, src_status};

  always_comb
  begin
    case (addr)
      `AIB_ADDR_TX_CFG:    rd_mux = cfg_rd;
      `AIB_ADDR_RX_STATUS: rd_mux = status_rd;
      `AIB_ADDR_ID:        rd_mux = `AIB_ID_VALUE;
      default:             rd_mux = '0;            // Spare address
    endcase
  end

  // rdata loads only on rd_en and holds between reads
  always_ff @(posedge src_clk or negedge src_rst_n)
  begin
    if (!src_rst_n)
    begin
      rdata    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_en;        // One cycle after the strobe
      if (rd_en)
        rdata <= rd_mux;
    end
  end

endmodule

// File: hdl/aib_status_collect.sv
/*
  Link-side status on dest_clk. Counts err_pulse while enabled, saturating at 255.
  err_clr is a level and holds count and flag at zero while set.
*/
`timescale 1ns/1ns

module aib_status_collect (
  input  logic                     dest_clk,     // Link clock
  input  logic                     dest_rst_n,   // Async reset
  input  logic                     link_up,      // Link level
  input  logic                     err_pulse,    // One-cycle error strobe
  input  aib_sync_pkg::tx_cfg_t    dest_cfg,     // Config after the crossing
  output aib_sync_pkg::rx_status_t dest_status   // Status word to src side
);

  aib_sync_pkg::err_count_t err_cnt_q;   // Error count
  logic                     err_seen_q;  // Sticky flag
  logic                     link_up_q;   // Registered link level
  logic                     cnt_hit;     // Pulse to be counted
  logic                     cnt_full;    // Counter at 255

  // ----------------------------------------------------------
  // Error counting
  // ----------------------------------------------------------
  assign cnt_full = &err_cnt_q;
  assign cnt_hit  = err_pulse && dest_cfg.enable;

  always_ff @(posedge dest_clk or negedge dest_rst_n)
  begin
    if (!dest_rst_n)
    begin
      err_cnt_q  <= '0;
      err_seen_q <= 1'b0;
    end
    else if (dest_cfg.err_clr)
    begin
      err_cnt_q  <= '0;              // Pulses dropped during clear
      err_seen_q <= 1'b0;
    end
    else if (cnt_hit)
    begin
      if (!cnt_full)
        err_cnt_q <= err_cnt_q + 1'b1;
      err_seen_q <= 1'b1;            // Stays set until err_clr
    end
  end

  // Link level, one flop
  always_ff @(posedge dest_clk or negedge dest_rst_n)
  begin
    if (!dest_rst_n)
      link_up_q <= 1'b0;
    else
      link_up_q <= link_up;
  end

  // ----------------------------------------------------------
  // Status word
  // ----------------------------------------------------------
  assign dest_status.link_up   = link_up_q;
  assign dest_status.err_seen  = err_seen_q;
  assign dest_status.err_count = err_cnt_q;

endmodule

// File: hdl/aib_cfg_sync_top.sv
/*
  Config out to dest_clk and status back to src_clk through two bus crossings.
  Both resets must already be synchronized. No completion signal for a crossing.
*/
`timescale 1ns/1ns

module aib_cfg_sync_top (
  input  logic                    src_clk,     // Register clock
  input  logic                    src_rst_n,   // Register side reset
  input  logic                    dest_clk,    // Link clock
  input  logic                    dest_rst_n,  // Link side reset
  input  logic                    wr_en,       // Register write strobe
  input  logic                    rd_en,       // Register read strobe
  input  aib_sync_pkg::cfg_addr_t addr,        // Register address
  input  aib_sync_pkg::cfg_data_t wdata,       // Register write data
  output aib_sync_pkg::cfg_data_t rdata,       // Register read data
  output logic                    rd_valid,    // Read data strobe
  input  logic                    link_up,     // Link level, dest_clk
  input  logic                    err_pulse,   // Error strobe, dest_clk
  output aib_sync_pkg::tx_cfg_t   dest_cfg     // Config in dest_clk domain
);

  localparam int CFG_W  = $bits(aib_sync_pkg::tx_cfg_t);
  localparam int STAT_W = $bits(aib_sync_pkg::rx_status_t);

  aib_sync_pkg::tx_cfg_t    src_cfg;      // Config, src side
  aib_sync_pkg::rx_status_t dest_status;  // Status, dest side
  aib_sync_pkg::rx_status_t src_status;   // Status after crossing

  // ----------------------------------------------------------
  // src_clk side
  // ----------------------------------------------------------
  aib_cfg_regs u_regs (
    .src_clk    (src_clk),
    .src_rst_n  (src_rst_n),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .addr       (addr),
    .wdata      (wdata),
    .src_status (src_status),
    .rdata      (rdata),
    .rd_valid   (rd_valid),
    .src_cfg    (src_cfg)
  );

  // Config toward the link
  aib_bus_sync #(.DWIDTH(CFG_W)) u_cfg_sync (
    .src_clk    (src_clk),
    .src_rst_n  (src_rst_n),
    .dest_clk   (dest_clk),
    .dest_rst_n (dest_rst_n),
    .src_data   (src_cfg),
    .dest_data  (dest_cfg)
  );

  // Status back to registers, clocks swapped
  aib_bus_sync #(.DWIDTH(STAT_W)) u_status_sync (
    .src_clk    (dest_clk),
    .src_rst_n  (dest_rst_n),
    .dest_clk   (src_clk),
    .dest_rst_n (src_rst_n),
    .src_data   (dest_status),
    .dest_data  (src_status)
  );

  // ----------------------------------------------------------
  // dest_clk side
  // ----------------------------------------------------------
  aib_status_collect u_status (
    .dest_clk    (dest_clk),
    .dest_rst_n  (dest_rst_n),
    .link_up     (link_up),
    .err_pulse   (err_pulse),
    .dest_cfg    (dest_cfg),
    .dest_status (dest_status)
  );

endmodule

// File: test/aib_cfg_sync_sva.sv
/*
  Port checks, bound to aib_cfg_sync_top. The dest_cfg check relies on
  a full round trip between samples, so AIB_SYNC_STAGES of 2 or more.
*/
`timescale 1ns/1ns

module aib_cfg_sync_sva (
  input logic                    src_clk,     // Register clock
  input logic                    src_rst_n,   // Register side reset
  input logic                    dest_clk,    // Link clock
  input logic                    dest_rst_n,  // Link side reset
  input logic                    rd_en,       // Read strobe
  input logic                    rd_valid,    // Read data strobe
  input aib_sync_pkg::cfg_data_t rdata,       // Read data
  input aib_sync_pkg::tx_cfg_t   dest_cfg     // Config after the crossing
);

  // ----------------------------------------------------------
  // Register port
  // ----------------------------------------------------------
  rd_valid_follows: assert property (
    @(posedge src_clk) disable iff (!src_rst_n)
    rd_en |=> rd_valid
  ) else $error("rd_valid missing one cycle after rd_en");

  // No stretched strobe
  rd_valid_single: assert property (
    @(posedge src_clk) disable iff (!src_rst_n)
    (rd_valid && !rd_en) |=> !rd_valid
  ) else $error("rd_valid high twice without a new rd_en");

  // ----------------------------------------------------------
  // Config crossing
  // ----------------------------------------------------------
  dest_cfg_whole: assert property (
    @(posedge dest_clk) disable iff (!dest_rst_n)
    !$stable(dest_cfg) |=> $stable(dest_cfg)      // New word then a hold
  ) else $error("dest_cfg changed on two cycles in a row");

  // Reset values
  src_zero_in_reset: assert property (
    @(posedge src_clk)
    !src_rst_n |-> (!rd_valid && (rdata == '0))
  ) else $error("rd_valid or rdata not zero during reset");

  dest_zero_in_reset: assert property (
    @(posedge dest_clk)
    !dest_rst_n |-> (dest_cfg == '0)
  ) else $error("dest_cfg not zero during reset");

endmodule

// File: test/tb_aib_cfg_sync.sv
/*
  Directed tests for the config/status crossing. No done signal exists,
  so dest_cfg and the status register are polled with a bound.
*/
`timescale 1ns/1ns
`include "aib_sync_config.svh"

module tb_aib_cfg_sync;

  // ----------------------------------------------------------
  // Timing and run length
  // ----------------------------------------------------------
  localparam int DEST_HALF = 2;                        // 4 ns dest_clk
  localparam int SRC_HALF  = 3;                        // 6 ns src_clk
  localparam int NUM_RAND  = 8;                        // Random config writes
  localparam int CFG_POLL  = 64;                       // dest_clk cycles
  localparam int STAT_POLL = 40;                       // Status reads
  localparam int STAT_W    = $bits(aib_sync_pkg::rx_status_t);
  // Config polls, status polls and pulse trains, worst case
  localparam int TEST_NS   = (NUM_RAND + 12) * CFG_POLL * 2 * DEST_HALF
                           + 12 * STAT_POLL * 6 * SRC_HALF + 300 * 4 * DEST_HALF;
  localparam int WATCHDOG_NS = 2 * TEST_NS;
  localparam aib_sync_pkg::cfg_addr_t ADDR_SPARE = 2'd3;  // Unmapped

  logic                    src_clk, src_rst_n, dest_clk, dest_rst_n;
  logic                    wr_en, rd_en, rd_valid, link_up, err_pulse;
  aib_sync_pkg::cfg_addr_t addr;
  aib_sync_pkg::cfg_data_t wdata, rdata;
  aib_sync_pkg::tx_cfg_t   dest_cfg;
  integer                  seed;
  aib_sync_pkg::tx_cfg_t   exp_cfg;    // Config register model
  int                      exp_count;  // Counted pulses, unsaturated
  logic                    exp_seen;   // Sticky flag model
  logic                    exp_link;   // Link level model

  always #(DEST_HALF) dest_clk = ~dest_clk;
  always #(SRC_HALF) src_clk = ~src_clk;

  aib_cfg_sync_top u_dut (
    .src_clk    (src_clk),
    .src_rst_n  (src_rst_n),
    .dest_clk   (dest_clk),
    .dest_rst_n (dest_rst_n),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .rd_valid   (rd_valid),
    .link_up    (link_up),
    .err_pulse  (err_pulse),
    .dest_cfg   (dest_cfg)
  );

  bind aib_cfg_sync_top aib_cfg_sync_sva u_sva (
    .src_clk    (src_clk),
    .src_rst_n  (src_rst_n),
    .dest_clk   (dest_clk),
    .dest_rst_n (dest_rst_n),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .rdata      (rdata),
    .dest_cfg   (dest_cfg)
  );

  // ----------------------------------------------------------
  // Reporting and compares
  // ----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_data(input string name, input aib_sync_pkg::cfg_data_t exp_v,
                            input aib_sync_pkg::cfg_data_t act_v);
    if (act_v !== exp_v)
      abort_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp_v, act_v));
  endtask

  task automatic check_cfg(input string name, input aib_sync_pkg::tx_cfg_t exp_v,
                           input aib_sync_pkg::tx_cfg_t act_v);
    if (act_v !== exp_v)
      abort_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp_v, act_v));
  endtask

  task automatic check_status(input string name, input aib_sync_pkg::rx_status_t exp_v,
                              input aib_sync_pkg::rx_status_t act_v);
    if (act_v !== exp_v)
      abort_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp_v, act_v));
  endtask

  // Status from the model, count saturates at 255
  function automatic aib_sync_pkg::rx_status_t model_status();
    aib_sync_pkg::rx_status_t s;
    s.link_up   = exp_link;
    s.err_seen  = exp_seen;
    s.err_count = (exp_count > 255) ? 8'd255 : exp_count[7:0];
    return s;
  endfunction

  // ----------------------------------------------------------
  // Bus and link drivers
  // ----------------------------------------------------------
  task automatic write_reg(input aib_sync_pkg::cfg_addr_t a, input aib_sync_pkg::cfg_data_t d);
    @(posedge src_clk);
    #1;
    wr_en = 1'b1;
    addr  = a;
    wdata = d;
    @(posedge src_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic read_reg(input aib_sync_pkg::cfg_addr_t a, output aib_sync_pkg::cfg_data_t d);
    @(posedge src_clk);
    #1;
    rd_en = 1'b1;
    addr  = a;
    @(posedge src_clk);
    #1;
    rd_en = 1'b0;
    if (!rd_valid)                   // Due one cycle after the strobe
      abort_run("Read strobe got no rd_valid back one cycle later");
    d = rdata;
  endtask

  task automatic send_pulses(input int n);
    repeat (n)
    begin
      @(posedge dest_clk);
      #1;
      err_pulse = 1'b1;
      @(posedge dest_clk);
      #1;
      err_pulse = 1'b0;  // One idle cycle between strobes
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge dest_clk);
    #1;
  endtask

  // Bounded polls
  task automatic wait_cfg(input aib_sync_pkg::tx_cfg_t exp_c);
    int cycles;
    cycles = 0;
    while (dest_cfg !== exp_c && cycles < CFG_POLL)
    begin
      @(posedge dest_clk);
      #1;
      cycles++;
    end
    if (dest_cfg !== exp_c)
      abort_run($sformatf("dest_cfg never reached 0x%h within %0d cycles", exp_c, CFG_POLL));
  endtask

  task automatic wait_status(input aib_sync_pkg::rx_status_t exp_s);
    aib_sync_pkg::cfg_data_t  rd;
    aib_sync_pkg::cfg_data_t  exp_word;
    int                       tries;
    tries = 0;
    exp_word = '0;
    exp_word[STAT_W-1:0] = exp_s;
    read_reg(`AIB_ADDR_RX_STATUS, rd);
    while (rd[STAT_W-1:0] !== exp_s && tries < STAT_POLL)
    begin
      read_reg(`AIB_ADDR_RX_STATUS, rd);
      tries++;
    end
    if (rd[STAT_W-1:0] !== exp_s)
      abort_run($sformatf("Status never reached 0x%h within %0d reads", exp_s, STAT_POLL));
    check_data("rdata", exp_word, rd);         // Upper bits read as zero
    read_reg(`AIB_ADDR_RX_STATUS, rd);         // Converged status holds
    check_status("rx_status", exp_s, rd[STAT_W-1:0]);
  endtask

  task automatic set_cfg(input logic en, input logic clr);
    exp_cfg.enable    = en;
    exp_cfg.err_clr   = clr;
    exp_cfg.tx_mode   = 2'b10;
    exp_cfg.lane_mask = 4'hF;
    write_reg(`AIB_ADDR_TX_CFG, {8'h00, exp_cfg});
    wait_cfg(exp_cfg);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    aib_sync_pkg::cfg_data_t rd;
    check_cfg("dest_cfg", '0, dest_cfg);
    read_reg(`AIB_ADDR_TX_CFG, rd);
    check_data("rdata", '0, rd);
    read_reg(`AIB_ADDR_RX_STATUS, rd);
    check_data("rdata", '0, rd);
    read_reg(`AIB_ADDR_ID, rd);
    check_data("rdata", `AIB_ID_VALUE, rd);
    read_reg(ADDR_SPARE, rd);
    check_data("rdata", '0, rd);
  endtask

  task automatic test_cfg_crossing();
    logic [31:0]             rnd;
    aib_sync_pkg::cfg_data_t rd;
    repeat (NUM_RAND)
    begin
      rnd = $random(seed);
      write_reg(`AIB_ADDR_TX_CFG, rnd[15:0]);
      exp_cfg = rnd[7:0];                      // Upper bits dropped
      read_reg(`AIB_ADDR_TX_CFG, rd);
      check_data("rdata", {8'h00, exp_cfg}, rd);
      wait_cfg(exp_cfg);
    end
  endtask

  task automatic test_read_only();
    logic [31:0]             rnd;
    aib_sync_pkg::cfg_data_t rd;
    rnd = $random(seed);
    write_reg(`AIB_ADDR_RX_STATUS, 16'hFFFF);
    write_reg(`AIB_ADDR_ID, rnd[15:0]);
    write_reg(ADDR_SPARE, rnd[31:16]);
    settle(40);                                // Room for a stray crossing
    read_reg(`AIB_ADDR_TX_CFG, rd);
    check_data("rdata", {8'h00, exp_cfg}, rd);
    wait_status(model_status());
    read_reg(`AIB_ADDR_ID, rd);
    check_data("rdata", `AIB_ID_VALUE, rd);
    read_reg(ADDR_SPARE, rd);
    check_data("rdata", '0, rd);
    check_cfg("dest_cfg", exp_cfg, dest_cfg);
  endtask

  task automatic test_error_count();
    set_cfg(1'b1, 1'b0);
    send_pulses(5);
    exp_count = 5;
    exp_seen  = 1'b1;
    wait_status(model_status());
    set_cfg(1'b0, 1'b0);                       // Disabled, nothing counted
    send_pulses(4);
    settle(40);
    wait_status(model_status());
    set_cfg(1'b1, 1'b0);
    send_pulses(260);
    exp_count = exp_count + 260;               // Past 255
    wait_status(model_status());
  endtask

  task automatic test_clear_link();
    set_cfg(1'b1, 1'b1);
    exp_count = 0;
    exp_seen  = 1'b0;
    wait_status(model_status());
    send_pulses(6);                            // Dropped during clear
    settle(40);
    wait_status(model_status());
    set_cfg(1'b1, 1'b0);
    @(posedge dest_clk);
    #1;
    link_up  = 1'b1;
    exp_link = 1'b1;
    wait_status(model_status());
    @(posedge dest_clk);
    #1;
    link_up  = 1'b0;
    exp_link = 1'b0;
    wait_status(model_status());
  endtask

  task automatic test_last_write();
    logic [31:0]             rnd;
    aib_sync_pkg::cfg_data_t rd;
    @(posedge src_clk);
    #1;
    wr_en = 1'b1;
    addr  = `AIB_ADDR_TX_CFG;
    repeat (4)                                 // One write per src cycle
    begin
      rnd     = $random(seed);
      wdata   = rnd[15:0];
      exp_cfg = rnd[7:0];
      @(posedge src_clk);
      #1;
    end
    wr_en = 1'b0;
    read_reg(`AIB_ADDR_TX_CFG, rd);
    check_data("rdata", {8'h00, exp_cfg}, rd);
    wait_cfg(exp_cfg);
  endtask

  // ----------------------------------------------------------
  // Sequence and watchdog
  // ----------------------------------------------------------
  initial
  begin
    seed       = 32'h24d7;
    src_clk    = 1'b0;
    dest_clk   = 1'b0;
    src_rst_n  = 1'b0;
    dest_rst_n = 1'b0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    addr       = '0;
    wdata      = '0;
    link_up    = 1'b0;
    err_pulse  = 1'b0;
    exp_cfg    = '0;
    exp_count  = 0;
    exp_seen   = 1'b0;
    exp_link   = 1'b0;
    fork
      begin
        repeat (3) @(posedge src_clk);
        #1;
        src_rst_n = 1'b1;
      end
      begin
        repeat (3) @(posedge dest_clk);
        #1;
        dest_rst_n = 1'b1;
      end
    join
    test_reset_state();
    test_cfg_crossing();
    test_read_only();
    test_error_count();
    test_clear_link();
    test_last_write();
    $display("Simulation passed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the tests finished");
  end

endmodule

// File: build.f
+incdir+include
hdl/aib_sync_pkg.sv
hdl/aib_bit_sync.sv
hdl/aib_bus_sync.sv
hdl/aib_cfg_regs.sv
hdl/aib_status_collect.sv
hdl/aib_cfg_sync_top.sv
test/aib_cfg_sync_sva.sv
test/tb_aib_cfg_sync.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.
# The exit status is nonzero if the build fails or the pass line is missing.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_aib_cfg_sync \
  && ./obj_dir/Vtb_aib_cfg_sync | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run_sim: simulation ok" \
  || { echo "run_sim: simulation not ok"; exit 1; }
